/* files.f */
src/xr_pkg.sv
src/xr_ram.sv
src/xr_regs.sv
src/xrmem_arb.sv
src/xr_mem_top.sv
tests/tb_xr_mem.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_xr_mem -f files.f \
    && ./obj_dir/Vtb_xr_mem | tee /dev/stderr | grep -q "TESTS PASSED" \
    && echo "simulation ok" \
    || { echo "simulation not ok"; exit 1; }

/* tests/tb_xr_mem.sv */
// XR memory block testbench
`default_nettype none
`timescale 1ns/1ps

module tb_xr_mem
    import xr_pkg::*;
();

    localparam int ACK_TIMEOUT = 20;
    localparam logic HOST = 1'b0;
    localparam logic COPP = 1'b1;

    // fixed rows carry their own expected read value
    typedef struct packed {
        logic  copp;
        logic  wr;
        addr_t addr;
        word_t data;
        logic  fixed;
        word_t exp_val;
    } row_t;

    logic        clk;
    logic        reset;
    xr_req_t     xr_req;
    logic        xr_ack;
    word_t       xr_data;
    copp_req_t   copp_req;
    logic        copp_ack;
    logic        color_sel;
    color_addr_t color_a_addr;
    color_addr_t color_b_addr;
    argb_t       color_a_data;
    argb_t       color_b_data;
    logic        tile_sel;
    tile_addr_t  tile_addr;
    word_t       tile_data;
    logic        copp_prog_sel;
    copp_addr_t  copp_prog_addr;
    copp_word_t  copp_prog_data;

    row_t  stim_q[$];
    // expected contents keyed by XR address
    word_t model[addr_t];
    int    errors;
    int    checks;
    int    tests;
    int    tests_failed;
    int    test_errors;

    xr_mem_top u_dut (
        .clk             (clk),
        .reset_i         (reset),
        .xr_req_i        (xr_req),
        .xr_ack_o        (xr_ack),
        .xr_data_o       (xr_data),
        .copp_req_i      (copp_req),
        .copp_ack_o      (copp_ack),
        .color_sel_i     (color_sel),
        .color_a_addr_i  (color_a_addr),
        .color_b_addr_i  (color_b_addr),
        .color_a_data_o  (color_a_data),
        .color_b_data_o  (color_b_data),
        .tile_sel_i      (tile_sel),
        .tile_addr_i     (tile_addr),
        .tile_data_o     (tile_data),
        .copp_prog_sel_i (copp_prog_sel),
        .copp_prog_addr_i(copp_prog_addr),
        .copp_prog_data_o(copp_prog_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic flag_error(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp_val);
        checks++;
        if (got !== exp_val) begin
            flag_error($sformatf("%s: got %h, expected %h", what, got, exp_val));
        end
    endtask

    task automatic check_argb(input string what, input argb_t got, input argb_t exp_val);
        checks++;
        if (got !== exp_val) begin
            flag_error($sformatf("%s: got %h, expected %h", what, got, exp_val));
        end
    endtask

    task automatic check_copp(input string what, input copp_word_t got,
                              input copp_word_t exp_val);
        checks++;
        if (got !== exp_val) begin
            flag_error($sformatf("%s: got %h, expected %h", what, got, exp_val));
        end
    endtask

    task automatic end_test(input string name);
        int n;
        n = errors - test_errors;
        tests++;
        if (n != 0) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, n);
        end else begin
            $display("test %s: ok", name);
        end
        test_errors = errors;
    endtask

    function automatic void add_row(input logic copp, input logic wr, input addr_t addr,
                                    input word_t data, input logic fixed, input word_t exp_val);
        row_t r;
        r = '{copp, wr, addr, data, fixed, exp_val};
        stim_q.push_back(r);
    endfunction

    function automatic void add_write(input logic copp, input addr_t addr);
        add_row(copp, 1'b1, addr, word_t'($urandom), 1'b0, '0);
    endfunction

    function automatic void add_read(input addr_t addr);
        add_row(HOST, 1'b0, addr, '0, 1'b0, '0);
    endfunction

    function automatic void add_read_fixed(input addr_t addr, input word_t exp_val);
        add_row(HOST, 1'b0, addr, '0, 1'b1, exp_val);
    endfunction

    // host access holding sel until the ack is seen at a falling edge
    task automatic host_access(input logic wr, input addr_t addr, input word_t data,
                               output word_t rdata);
        int cycles;
        cycles = 0;
        rdata = '0;
        @(negedge clk);
        xr_req.sel = 1'b1;
        xr_req.wr = wr;
        xr_req.addr = addr;
        xr_req.data = data;
        while (!xr_ack && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        xr_req.sel = 1'b0;
        if (!xr_ack) begin
            $display("ERROR at %0t ns: host ack never came for address %h", $time, addr);
            errors++;
        end else begin
            rdata = xr_data;
            if (cycles != 1) begin
                flag_error($sformatf("host ack for %h after %0d cycles", addr, cycles));
            end
            @(negedge clk);
            if (xr_ack) begin
                flag_error($sformatf("host ack for %h longer than one cycle", addr));
            end
        end
    endtask

    task automatic copp_write(input addr_t addr, input word_t data);
        int cycles;
        cycles = 0;
        @(negedge clk);
        copp_req.sel = 1'b1;
        copp_req.addr = addr;
        copp_req.data = data;
        while (!copp_ack && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        copp_req.sel = 1'b0;
        if (!copp_ack) begin
            $display("ERROR at %0t ns: copper ack never came for address %h", $time, addr);
            errors++;
        end else begin
            if (cycles != 1) begin
                flag_error($sformatf("copper ack for %h after %0d cycles", addr, cycles));
            end
            @(negedge clk);
            if (copp_ack) begin
                flag_error($sformatf("copper ack for %h longer than one cycle", addr));
            end
        end
    endtask

    task automatic build_stimulus();
        // every register is clear after reset
        for (int i = 0; i < 16; i++) begin
            add_read_fixed(addr_t'(i), '0);
        end
        // version word ignores writes and unmapped registers read zero
        add_read_fixed(16'h0010, XR_VERSION);
        add_write(HOST, 16'h0010);
        add_read_fixed(16'h0010, XR_VERSION);
        add_read_fixed(16'h0020, '0);
        add_read_fixed(16'h007f, '0);
        add_write(HOST, 16'h0003);
        add_read(16'h0003);
        add_write(HOST, 16'h000f);
        add_read(16'h000f);
        // playfields A and B at the same index
        add_write(HOST, 16'h4012);
        add_write(HOST, 16'h4112);
        add_read(16'h4012);
        add_write(HOST, 16'h4012);
        add_read(16'h4112);
        add_read(16'h4012);
        add_write(HOST, 16'h4134);
        // both tile banks at the same low address
        add_write(HOST, 16'h8020);
        add_write(HOST, 16'h9020);
        add_read(16'h8020);
        add_write(HOST, 16'h8020);
        add_read(16'h9020);
        add_read(16'h8020);
        // even and odd copper halves
        add_write(HOST, 16'hc010);
        add_write(HOST, 16'hc011);
        add_read(16'hc010);
        add_read(16'hc011);
        // writes through the copper port
        add_write(COPP, 16'hc020);
        add_write(COPP, 16'hc021);
        add_write(COPP, 16'h0007);
        add_read(16'hc020);
        add_read(16'hc021);
        add_read(16'h0007);
    endtask

    task automatic run_stimulus();
        row_t  r;
        word_t got;
        word_t exp_val;
        foreach (stim_q[i]) begin
            r = stim_q[i];
            if (r.copp) begin
                copp_write(r.addr, r.data);
                model[r.addr] = r.data;
            end else if (r.wr) begin
                host_access(1'b1, r.addr, r.data, got);
                model[r.addr] = r.data;
            end else begin
                host_access(1'b0, r.addr, '0, got);
                exp_val = r.fixed ? r.exp_val : model[r.addr];
                check_word($sformatf("host read %h", r.addr), got, exp_val);
            end
        end
    endtask

    // video addresses map back onto XR addresses of the same entry
    task automatic video_read(input color_addr_t ca, input color_addr_t cb,
                              input tile_addr_t ta, input copp_addr_t pa);
        addr_t even;
        even = {REGION_COPP, 3'b000, pa, 1'b0};
        @(negedge clk);
        color_sel = 1'b1;
        color_a_addr = ca;
        color_b_addr = cb;
        tile_sel = 1'b1;
        tile_addr = ta;
        copp_prog_sel = 1'b1;
        copp_prog_addr = pa;
        @(negedge clk);
        check_argb("video color a", color_a_data, model[{REGION_COLOR, 6'b0, ca}]);
        check_argb("video color b", color_b_data, model[{REGION_COLOR, 5'b0, 1'b1, cb}]);
        check_word("video tile", tile_data, model[{REGION_TILE, 1'b0, ta}]);
        check_copp("video copper", copp_prog_data, {model[even], model[even | 16'h0001]});
        color_sel = 1'b0;
        tile_sel = 1'b0;
        copp_prog_sel = 1'b0;
    endtask

    task automatic copper_priority(input addr_t caddr, input word_t cdata,
                                   input addr_t haddr, input word_t hdata);
        int    cycles;
        int    copp_cyc;
        int    host_cyc;
        word_t got;
        cycles = 0;
        copp_cyc = 0;
        host_cyc = 0;
        @(negedge clk);
        copp_req.sel = 1'b1;
        copp_req.addr = caddr;
        copp_req.data = cdata;
        xr_req.sel = 1'b1;
        xr_req.wr = 1'b1;
        xr_req.addr = haddr;
        xr_req.data = hdata;
        while ((copp_req.sel || xr_req.sel) && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (xr_ack && copp_req.sel) begin
                flag_error("host acked while copper sel high");
            end
            if (copp_ack && copp_req.sel) begin
                copp_cyc = cycles;
                copp_req.sel = 1'b0;
            end
            if (xr_ack && xr_req.sel) begin
                host_cyc = cycles;
                xr_req.sel = 1'b0;
            end
        end
        if (copp_req.sel || xr_req.sel) begin
            $display("ERROR at %0t ns: an ack never came with both ports busy", $time);
            errors++;
            copp_req.sel = 1'b0;
            xr_req.sel = 1'b0;
        end else if (copp_cyc != 1 || host_cyc <= copp_cyc) begin
            flag_error($sformatf("ack order: copper cycle %0d, host cycle %0d",
                                 copp_cyc, host_cyc));
        end
        model[caddr] = cdata;
        model[haddr] = hdata;
        host_access(1'b0, caddr, '0, got);
        check_word("copper write read-back", got, cdata);
        host_access(1'b0, haddr, '0, got);
        check_word("host write read-back", got, hdata);
    endtask

    // host read of color memory stalls while the video select is high
    task automatic color_backpressure(input addr_t addr, input int hold);
        int cycles;
        cycles = 0;
        @(negedge clk);
        color_sel = 1'b1;
        xr_req.sel = 1'b1;
        xr_req.wr = 1'b0;
        xr_req.addr = addr;
        xr_req.data = '0;
        repeat (hold) begin
            @(negedge clk);
            if (xr_ack) begin
                flag_error("host read acked while color select held");
            end
        end
        color_sel = 1'b0;
        while (!xr_ack && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        xr_req.sel = 1'b0;
        if (!xr_ack) begin
            $display("ERROR at %0t ns: held color read was never acked", $time);
            errors++;
        end else begin
            check_word("held color read", xr_data, model[addr]);
            if (cycles != 1) begin
                flag_error($sformatf("held read acked %0d cycles after release", cycles));
            end
        end
    endtask

    initial begin
        void'($urandom(32'h4c65));
        reset = 1'b1;
        xr_req = '0;
        copp_req = '0;
        color_sel = 1'b0;
        color_a_addr = '0;
        color_b_addr = '0;
        tile_sel = 1'b0;
        tile_addr = '0;
        copp_prog_sel = 1'b0;
        copp_prog_addr = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        tests_failed = 0;
        test_errors = 0;
        build_stimulus();
        repeat (2) @(negedge clk);
        // requests pending during reset are never acked
        xr_req.sel = 1'b1;
        repeat (3) begin
            @(negedge clk);
            checks++;
            if (xr_ack !== 1'b0) begin
                flag_error("host ack during reset");
            end
        end
        xr_req.sel = 1'b0;
        copp_req.sel = 1'b1;
        repeat (3) begin
            @(negedge clk);
            checks++;
            if (copp_ack !== 1'b0) begin
                flag_error("copper ack during reset");
            end
        end
        copp_req.sel = 1'b0;
        reset = 1'b0;
        @(negedge clk);
        checks++;
        if (xr_ack !== 1'b0 || copp_ack !== 1'b0) begin
            flag_error("ack high after reset");
        end
        end_test("reset");
        run_stimulus();
        end_test("region table");
        video_read(8'h12, 8'h12, 13'h0020, 10'd8);
        video_read(8'h12, 8'h34, 13'h1020, 10'd16);
        end_test("video ports");
        copper_priority(16'hc030, word_t'($urandom), 16'h4033, word_t'($urandom));
        end_test("copper priority");
        color_backpressure(16'h4112, 5);
        end_test("color back-pressure");
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/xr_mem_top.sv */
// XR memory block top level
`default_nettype none
`timescale 1ns/1ps

module xr_mem_top
    import xr_pkg::*;
#(
    parameter int EN_VID_PF_B = 1
) (
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  wire xr_req_t     xr_req_i,
    output      logic        xr_ack_o,
    output      word_t       xr_data_o,
    input  wire copp_req_t   copp_req_i,
    output      logic        copp_ack_o,
    input  wire logic        color_sel_i,
    input  wire color_addr_t color_a_addr_i,
    input  wire color_addr_t color_b_addr_i,
    output      argb_t       color_a_data_o,
    output      argb_t       color_b_data_o,
    input  wire logic        tile_sel_i,
    input  wire tile_addr_t  tile_addr_i,
    output      word_t       tile_data_o,
    input  wire logic        copp_prog_sel_i,
    input  wire copp_addr_t  copp_prog_addr_i,
    output      copp_word_t  copp_prog_data_o
);

    // register bus between arbiter and register file
    xreg_bus_t xreg_bus;
    word_t     xreg_data;

    xrmem_arb #(.EN_VID_PF_B(EN_VID_PF_B)) u_arb (
        .clk             (clk),
        .reset_i         (reset_i),
        .xr_req_i        (xr_req_i),
        .xr_ack_o        (xr_ack_o),
        .xr_data_o       (xr_data_o),
        .copp_req_i      (copp_req_i),
        .copp_ack_o      (copp_ack_o),
        .xreg_o          (xreg_bus),
        .xreg_data_i     (xreg_data),
        .color_sel_i     (color_sel_i),
        .color_a_addr_i  (color_a_addr_i),
        .color_b_addr_i  (color_b_addr_i),
        .color_a_data_o  (color_a_data_o),
        .color_b_data_o  (color_b_data_o),
        .tile_sel_i      (tile_sel_i),
        .tile_addr_i     (tile_addr_i),
        .tile_data_o     (tile_data_o),
        .copp_prog_sel_i (copp_prog_sel_i),
        .copp_prog_addr_i(copp_prog_addr_i),
        .copp_prog_data_o(copp_prog_data_o)
    );

    xr_regs u_regs (
        .clk        (clk),
        .reset_i    (reset_i),
        .xreg_i     (xreg_bus),
        .xreg_data_o(xreg_data)
    );

endmodule

`default_nettype wire

/* src/xrmem_arb.sv */
// XR memory arbiter
`default_nettype none
`timescale 1ns/1ps

module xrmem_arb
    import xr_pkg::*;
#(
    parameter int EN_VID_PF_B = 1
) (
    input  wire logic        clk,
    input  wire logic        reset_i,
    // host port
    input  wire xr_req_t     xr_req_i,
    output      logic        xr_ack_o,
    output      word_t       xr_data_o,
    // copper port, writes only
    input  wire copp_req_t   copp_req_i,
    output      logic        copp_ack_o,
    // register file bus
    output      xreg_bus_t   xreg_o,
    input  wire word_t       xreg_data_i,
    // video read ports
    input  wire logic        color_sel_i,
    input  wire color_addr_t color_a_addr_i,
    input  wire color_addr_t color_b_addr_i,
    output      argb_t       color_a_data_o,
    output      argb_t       color_b_data_o,
    input  wire logic        tile_sel_i,
    input  wire tile_addr_t  tile_addr_i,
    output      word_t       tile_data_o,
    input  wire logic        copp_prog_sel_i,
    input  wire copp_addr_t  copp_prog_addr_i,
    output      copp_word_t  copp_prog_data_o
);

    logic [1:0]  host_region;
    logic [1:0]  wr_region;
    logic        copp_go;
    logic        host_go;
    logic        host_rd_ok;
    logic        host_issue;
    logic        wr_active;
    addr_t       wr_addr;
    word_t       wr_data;

    // RAM read side
    color_addr_t color_a_rd_addr;
    argb_t       color_a_q;
    argb_t       color_b_q;
    tile_addr_t  tile_rd_addr;
    logic        tile_bank_q;
    word_t       tile_q;
    word_t       tile2_q;
    copp_addr_t  copp_rd_addr;
    copp_word_t  copp_q;

    // host read result selection, captured when the read is issued
    logic [1:0]  rd_region_q;
    logic        rd_color_b_q;
    logic        rd_copp_odd_q;
    word_t       xreg_rd_q;

    assign host_region = xr_req_i.addr[15:14];

    // copper owns the write path whenever it has an un-acked request
    assign copp_go = copp_req_i.sel & ~copp_ack_o;
    // host waits for any copper sel to drop
    assign host_go = xr_req_i.sel & ~xr_ack_o & ~copp_req_i.sel;

    // video selects hold off host reads of their own region
    always_comb begin
        unique case (host_region)
            REGION_REGS: host_rd_ok = 1'b1;
            REGION_COLOR: host_rd_ok = ~color_sel_i;
            REGION_TILE: host_rd_ok = ~tile_sel_i;
            default: host_rd_ok = ~copp_prog_sel_i;
        endcase
    end

    // writes use separate RAM ports so they are never blocked
    assign host_issue = host_go & (xr_req_i.wr | host_rd_ok);

    assign wr_addr = copp_go ? copp_req_i.addr : xr_req_i.addr;
    assign wr_data = copp_go ? copp_req_i.data : xr_req_i.data;
    assign wr_region = wr_addr[15:14];
    assign wr_active = copp_go | (host_go & xr_req_i.wr);

    assign xreg_o.wr = wr_active & (wr_region == REGION_REGS);
    assign xreg_o.addr = wr_addr[XREG_W-1:0];
    assign xreg_o.data = wr_data;

    // read address muxes, video first
    assign color_a_rd_addr = color_sel_i ? color_a_addr_i : xr_req_i.addr[COLOR_W-1:0];
    assign tile_rd_addr = tile_sel_i ? tile_addr_i : xr_req_i.addr[TILE_W-1:0];
    assign copp_rd_addr = copp_prog_sel_i ? copp_prog_addr_i : xr_req_i.addr[COPP_W:1];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            xr_ack_o <= 1'b0;
            copp_ack_o <= 1'b0;
        end else begin
            xr_ack_o <= host_issue;
            copp_ack_o <= copp_go;
        end
    end

    // bank of the read just presented to the tile RAMs
    always_ff @(posedge clk) begin
        tile_bank_q <= tile_rd_addr[TILE_W-1];
    end

    always_ff @(posedge clk) begin
        if (host_issue) begin
            rd_region_q <= host_region;
            rd_color_b_q <= xr_req_i.addr[COLOR_W];
            rd_copp_odd_q <= xr_req_i.addr[0];
            xreg_rd_q <= xreg_data_i;
        end
    end

    assign color_a_data_o = color_a_q;
    assign color_b_data_o = color_b_q;
    assign tile_data_o = tile_bank_q ? tile2_q : tile_q;
    assign copp_prog_data_o = copp_q;

    always_comb begin
        unique case (rd_region_q)
            REGION_REGS: xr_data_o = xreg_rd_q;
            REGION_COLOR: xr_data_o = rd_color_b_q ? color_b_q : color_a_q;
            REGION_TILE: xr_data_o = tile_data_o;
            default: xr_data_o = rd_copp_odd_q ? copp_q[15:0] : copp_q[31:16];
        endcase
    end

    xr_ram #(.AWIDTH(COLOR_W)) color_a_ram (
        .clk      (clk),
        .wr_en_i  (wr_active & (wr_region == REGION_COLOR) & ~wr_addr[COLOR_W]),
        .wr_addr_i(wr_addr[COLOR_W-1:0]),
        .wr_data_i(wr_data),
        .rd_addr_i(color_a_rd_addr),
        .rd_data_o(color_a_q)
    );

    // playfield B is optional
    generate
        if (EN_VID_PF_B != 0) begin : g_pf_b
            color_addr_t color_b_rd_addr;

            assign color_b_rd_addr = color_sel_i ? color_b_addr_i
                                                 : xr_req_i.addr[COLOR_W-1:0];

            xr_ram #(.AWIDTH(COLOR_W)) color_b_ram (
                .clk      (clk),
                .wr_en_i  (wr_active & (wr_region == REGION_COLOR) & wr_addr[COLOR_W]),
                .wr_addr_i(wr_addr[COLOR_W-1:0]),
                .wr_data_i(wr_data),
                .rd_addr_i(color_b_rd_addr),
                .rd_data_o(color_b_q)
            );
        end else begin : g_no_pf_b
            assign color_b_q = '0;
        end
    endgenerate

    // 4K main tile bank
    xr_ram #(.AWIDTH(TILE_W-1)) tile_ram (
        .clk      (clk),
        .wr_en_i  (wr_active & (wr_region == REGION_TILE) & ~wr_addr[TILE_W-1]),
        .wr_addr_i(wr_addr[TILE_W-2:0]),
        .wr_data_i(wr_data),
        .rd_addr_i(tile_rd_addr[TILE_W-2:0]),
        .rd_data_o(tile_q)
    );

    // 1K second tile bank
    xr_ram #(.AWIDTH(TILE2_W)) tile2_ram (
        .clk      (clk),
        .wr_en_i  (wr_active & (wr_region == REGION_TILE) & wr_addr[TILE_W-1]),
        .wr_addr_i(wr_addr[TILE2_W-1:0]),
        .wr_data_i(wr_data),
        .rd_addr_i(tile_rd_addr[TILE2_W-1:0]),
        .rd_data_o(tile2_q)
    );

    // even XR word is the upper half of the copper instruction
    xr_ram #(.AWIDTH(COPP_W)) copp_even_ram (
        .clk      (clk),
        .wr_en_i  (wr_active & (wr_region == REGION_COPP) & ~wr_addr[0]),
        .wr_addr_i(wr_addr[COPP_W:1]),
        .wr_data_i(wr_data),
        .rd_addr_i(copp_rd_addr),
        .rd_data_o(copp_q[31:16])
    );

    xr_ram #(.AWIDTH(COPP_W)) copp_odd_ram (
        .clk      (clk),
        .wr_en_i  (wr_active & (wr_region == REGION_COPP) & wr_addr[0]),
        .wr_addr_i(wr_addr[COPP_W:1]),
        .wr_data_i(wr_data),
        .rd_addr_i(copp_rd_addr),
        .rd_data_o(copp_q[15:0])
    );

    a_ack_exclusive : assert property (
        @(posedge clk) disable iff (reset_i)
        !(xr_ack_o && copp_ack_o)
    );

    // an ack always answers a sel seen one cycle earlier
    a_xr_ack_sel : assert property (
        @(posedge clk) disable iff (reset_i)
        xr_ack_o |-> $past(xr_req_i.sel)
    );

    a_copp_ack_sel : assert property (
        @(posedge clk) disable iff (reset_i)
        copp_ack_o |-> $past(copp_req_i.sel)
    );

endmodule

`default_nettype wire

/* src/xr_regs.sv */
// XR configuration registers
`default_nettype none
`timescale 1ns/1ps

module xr_regs
    import xr_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset_i,
    input  wire xreg_bus_t xreg_i,
    output      word_t     xreg_data_o
);

    word_t regs [16];
    logic  in_file;

    // addresses 0..15 map onto the register file
    assign in_file = (xreg_i.addr[XREG_W-1:4] == '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (xreg_i.wr && in_file) begin
            regs[xreg_i.addr[3:0]] <= xreg_i.data;
        end
    end

    // read is combinational for the address on the bus
    always_comb begin
        if (in_file) begin
            xreg_data_o = regs[xreg_i.addr[3:0]];
        end else if (xreg_i.addr == xreg_addr_t'(16)) begin
            xreg_data_o = XR_VERSION;
        end else begin
            xreg_data_o = '0;
        end
    end

    // writes outside the file are dropped, but their data should still be clean
    a_hi_wr_known : assert property (
        @(posedge clk) disable iff (reset_i)
        (xreg_i.wr && !in_file) |-> !$isunknown(xreg_i.data)
    );

endmodule

`default_nettype wire

/* src/xr_ram.sv */
// generic word RAM
`default_nettype none
`timescale 1ns/1ps

module xr_ram
    import xr_pkg::*;
#(
    parameter int AWIDTH = 8
) (
    input  wire logic              clk,
    input  wire logic              wr_en_i,
    input  wire logic [AWIDTH-1:0] wr_addr_i,
    input  wire word_t             wr_data_i,
    input  wire logic [AWIDTH-1:0] rd_addr_i,
    output      word_t             rd_data_o
);

    // contents are left uninitialized
    word_t mem [2**AWIDTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // one cycle read latency, old data on a same-address write
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

`default_nettype wire

/* src/xr_pkg.sv */
// XR memory shared definitions
`default_nettype none

package xr_pkg;

    // address widths of each memory
    localparam int COLOR_W = 8;
    localparam int TILE_W = 13;
    localparam int TILE2_W = 10;
    localparam int COPP_W = 10;
    localparam int XREG_W = 7;

    localparam logic [15:0] XR_VERSION = 16'h0103;

    // top two XR address bits
    localparam logic [1:0] REGION_REGS = 2'b00;
    localparam logic [1:0] REGION_COLOR = 2'b01;
    localparam logic [1:0] REGION_TILE = 2'b10;
    localparam logic [1:0] REGION_COPP = 2'b11;

    typedef logic [15:0] word_t;
    typedef logic [15:0] addr_t;
    typedef logic [15:0] argb_t;
    typedef logic [COLOR_W-1:0] color_addr_t;
    typedef logic [TILE_W-1:0] tile_addr_t;
    typedef logic [COPP_W-1:0] copp_addr_t;
    typedef logic [31:0] copp_word_t;
    typedef logic [XREG_W-1:0] xreg_addr_t;

    // host port request, read or write
    typedef struct packed {
        logic  sel;
        logic  wr;
        addr_t addr;
        word_t data;
    } xr_req_t;

    // copper port request, write only
    typedef struct packed {
        logic  sel;
        addr_t addr;
        word_t data;
    } copp_req_t;

    typedef struct packed {
        logic       wr;
        xreg_addr_t addr;
        word_t      data;
    } xreg_bus_t;

endpackage

`default_nettype wire
